//--- hw/npc_pkg.sv
package npc_pkg;

    // data and address width
    localparam int xlen = 32;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // program and data memory, in words
    localparam int mem_words = 1024;
    localparam int mem_aw = $clog2(mem_words);

    // major opcodes of the supported subset
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_jalr = 7'b1100111;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_load = 7'b0000011;

    // funct3 values, 000 is also the jalr encoding
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_lw = 3'b010;

    localparam logic [xlen-1:0] ebreak_word = 32'h0010_0073;

    // one-hot alu operation, bit index per instruction
    localparam int alu_op_w = 7;
    localparam int aop_auipc = 0;
    localparam int aop_lui = 1;
    localparam int aop_jal = 2;
    localparam int aop_jalr = 3;
    localparam int aop_addi = 4;
    localparam int aop_add = 5;
    localparam int aop_lw = 6;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_i_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_u_t;

    // jump offset bits are scattered across the upper word
    typedef struct packed {
        logic imm_20;
        logic [9:0] imm_10_1;
        logic imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    typedef union packed {
        logic [xlen-1:0] raw;
        inst_r_t r;
        inst_i_t i;
        inst_u_t u;
        inst_j_t j;
    } inst_u;

endpackage

//--- hw/inst_decode.sv
module inst_decode import npc_pkg::*; (
    input  inst_u                 inst,
    output logic [4:0]            rs1,
    output logic [4:0]            rs2,
    output logic [4:0]            rd,
    output logic [xlen-1:0]       imm,
    output logic [alu_op_w-1:0]   alu_op,
    output logic                  reg_wen,
    output logic                  mem_en
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    // register fields sit at the same place in every format
    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;
    assign rs1 = inst.r.rs1;
    assign rs2 = inst.r.rs2;
    assign rd = inst.r.rd;

    // sign-extended immediates, one per format
    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_u = {inst.u.imm, 12'b0};
    assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                    inst.j.imm_11, inst.j.imm_10_1, 1'b0};

    // pick the immediate by opcode class
    always_comb begin
        case (opcode)
            op_imm, op_load, op_jalr: begin
                imm = imm_i;
            end
            op_lui, op_auipc: begin
                imm = imm_u;
            end
            op_jal: begin
                imm = imm_j;
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    // one operation bit per recognized instruction
    always_comb begin
        alu_op = '0;
        case (opcode)
            op_lui: begin
                alu_op[aop_lui] = 1'b1;
            end
            op_auipc: begin
                alu_op[aop_auipc] = 1'b1;
            end
            op_jal: begin
                alu_op[aop_jal] = 1'b1;
            end
            op_jalr: begin
                alu_op[aop_jalr] = (funct3 == f3_add);
            end
            op_imm: begin
                alu_op[aop_addi] = (funct3 == f3_add);
            end
            op_reg: begin
                // sub shares this funct3 so funct7 must be zero
                alu_op[aop_add] = (funct3 == f3_add) && (inst.r.funct7 == 7'd0);
            end
            op_load: begin
                alu_op[aop_lw] = (funct3 == f3_lw);
            end
            default: begin
                alu_op = '0;
            end
        endcase
    end

    // every supported instruction writes rd
    assign reg_wen = |alu_op;
    assign mem_en = alu_op[aop_lw];

endmodule

//--- hw/alu.sv
module alu import npc_pkg::*; (
    input  logic [alu_op_w-1:0] alu_op,
    input  logic [xlen-1:0]     src1,
    input  logic [xlen-1:0]     src2,
    input  logic [xlen-1:0]     imm,
    input  logic [xlen-1:0]     pc,
    input  logic [xlen-1:0]     rdata,
    output logic [xlen-1:0]     result,
    output logic [xlen-1:0]     next_pc
);

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] jalr_sum;

    assign pc_plus4 = pc + xlen'(4);
    assign jalr_sum = src1 + imm;

    // write-back value, zero when no operation is set
    always_comb begin
        case (1'b1)
            alu_op[aop_auipc]: begin
                result = pc + imm;
            end
            alu_op[aop_lui]: begin
                result = imm;
            end
            alu_op[aop_jal], alu_op[aop_jalr]: begin
                // link address
                result = pc_plus4;
            end
            alu_op[aop_addi]: begin
                result = src1 + imm;
            end
            alu_op[aop_add]: begin
                result = src1 + src2;
            end
            alu_op[aop_lw]: begin
                result = rdata;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // jalr target drops bit 0
    always_comb begin
        if (alu_op[aop_jal]) begin
            next_pc = pc + imm;
        end else if (alu_op[aop_jalr]) begin
            next_pc = {jalr_sum[xlen-1:1], 1'b0};
        end else begin
            next_pc = pc_plus4;
        end
    end

endmodule

//--- hw/reg_file.sv
module reg_file import npc_pkg::*; (
    input  logic            clk,
    input  logic            wen,
    input  logic [4:0]      waddr,
    input  logic [xlen-1:0] wdata,
    input  logic [4:0]      raddr1,
    output logic [xlen-1:0] rdata1,
    input  logic [4:0]      raddr2,
    output logic [xlen-1:0] rdata2
);

    // x1..x31 only, x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wen && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads, x0 reads zero
    always_comb begin
        if (raddr1 == 5'd0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == 5'd0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

//--- hw/pmem.sv
module pmem import npc_pkg::*; (
    input  logic              clk,
    input  logic              wen,
    input  logic [mem_aw-1:0] waddr,
    input  logic [xlen-1:0]   wdata,
    input  logic [mem_aw-1:0] fetch_addr,
    output logic [xlen-1:0]   fetch_data,
    input  logic [mem_aw-1:0] load_addr,
    output logic [xlen-1:0]   load_data
);

    // shared instruction and data storage, word indexed
    logic [xlen-1:0] mem [mem_words];

    // program image is written one word per clock
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // instruction fetch
    assign fetch_data = mem[fetch_addr];

    // lw data, seen in the same cycle as the address
    assign load_data = mem[load_addr];

endmodule

//--- hw/npc.sv
module npc import npc_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_en,
    input  logic [mem_aw-1:0] load_addr,
    input  logic [xlen-1:0]   load_data,
    output logic [xlen-1:0]   pc,
    output logic [xlen-1:0]   alu_result,
    output logic              halted
);

    inst_u inst;
    logic [xlen-1:0] fetch_word;
    logic [xlen-1:0] mem_word;
    logic [xlen-1:0] rdata;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic [xlen-1:0] imm;
    logic [alu_op_w-1:0] alu_op;
    logic reg_wen;
    logic mem_en;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] pc_off;
    logic [xlen-1:0] ld_off;

    // byte offsets from the memory base give the word index
    assign pc_off = pc - reset_pc;
    assign ld_off = src1 + imm - reset_pc;

    assign inst = fetch_word;
    assign rdata = mem_en ? mem_word : '0;

    // pc stops on the ebreak and holds there until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
            halted <= 1'b0;
        end else begin
            if (inst.raw == ebreak_word) begin
                halted <= 1'b1;
            end else if (!halted) begin
                pc <= next_pc;
            end
        end
    end

    inst_decode u_decode (
        .inst    (inst),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .imm     (imm),
        .alu_op  (alu_op),
        .reg_wen (reg_wen),
        .mem_en  (mem_en)
    );

    alu u_alu (
        .alu_op  (alu_op),
        .src1    (src1),
        .src2    (src2),
        .imm     (imm),
        .pc      (pc),
        .rdata   (rdata),
        .result  (alu_result),
        .next_pc (next_pc)
    );

    reg_file u_regs (
        .clk    (clk),
        .wen    (reg_wen && !halted),
        .waddr  (rd),
        .wdata  (alu_result),
        .raddr1 (rs1),
        .rdata1 (src1),
        .raddr2 (rs2),
        .rdata2 (src2)
    );

    pmem u_pmem (
        .clk        (clk),
        .wen        (load_en),
        .waddr      (load_addr),
        .wdata      (load_data),
        .fetch_addr (pc_off[mem_aw+1:2]),
        .fetch_data (fetch_word),
        .load_addr  (ld_off[mem_aw+1:2]),
        .load_data  (mem_word)
    );

    // jalr with an odd-halfword offset would break this
    pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

    // program loading only while the core is held in reset
    load_in_reset: assert property (@(posedge clk) load_en |-> rst)
        else $error("load_en asserted outside reset");

endmodule

//--- testbench/npc_tests.svh
task automatic test_reset();
    prog = {32'h0000_0000, ebreak_word};
    reset_core();
    check_word("reset pc", reset_pc, pc);
    check_flag("reset halted", 1'b0, halted);
    // opcode zero is not supported
    retire("reset no-op", '0, reset_pc + 4);
endtask

task automatic test_arith();
    logic [11:0] a;
    logic [11:0] b;
    logic [xlen-1:0] v1;
    logic [xlen-1:0] v2;
    logic [xlen-1:0] v3;
    a = 12'($random(seed));
    b = 12'($random(seed));
    v1 = sext12(a);
    v2 = v1 + sext12(b);
    v3 = v1 + v2;
    prog = {i_type(a, 5'd0, f3_add, 5'd1, op_imm), i_type(b, 5'd1, f3_add, 5'd2, op_imm),
            r_type(5'd2, 5'd1, 5'd3), i_type(a, 5'd3, f3_add, 5'd0, op_imm),
            r_type(5'd3, 5'd0, 5'd4), ebreak_word};
    reset_core();
    retire("arith addi", v1, reset_pc + 4);
    retire("arith addi chain", v2, reset_pc + 8);
    retire("arith add", v3, reset_pc + 12);
    retire("arith write x0", v3 + sext12(a), reset_pc + 16);
    // x0 must still read zero
    retire("arith read x0", v3, reset_pc + 20);
endtask

task automatic test_upper();
    logic [19:0] u1;
    logic [19:0] u2;
    u1 = 20'($random(seed));
    u2 = 20'($random(seed));
    prog = {u_type(u1, 5'd5, op_lui), u_type(u2, 5'd6, op_auipc), ebreak_word};
    reset_core();
    retire("upper lui", {u1, 12'h000}, reset_pc + 4);
    retire("upper auipc", reset_pc + 4 + {u2, 12'h000}, reset_pc + 8);
endtask

task automatic test_jumps();
    logic [xlen-1:0] skip;
    skip = i_type(12'd1, 5'd0, f3_add, 5'd9, op_imm);
    // jal over word 1, jalr with an odd offset lands on word 6
    prog = {j_type(21'd8, 5'd1), skip, u_type(20'h80000, 5'd7, op_lui),
            i_type(12'd25, 5'd7, f3_add, 5'd2, op_jalr), skip, skip, ebreak_word};
    reset_core();
    retire("jal link", reset_pc + 4, reset_pc + 8);
    retire("jumps lui base", 32'h8000_0000, reset_pc + 12);
    retire("jalr link", reset_pc + 16, (32'h8000_0000 + 32'd25) & ~32'd1);
endtask

task automatic test_load();
    prog = {u_type(20'h80000, 5'd8, op_lui), i_type(12'd64, 5'd8, f3_lw, 5'd10, op_load),
            i_type(12'd128, 5'd8, f3_add, 5'd9, op_imm),
            i_type(12'hfe0, 5'd9, f3_lw, 5'd12, op_load),
            {7'd0, 5'd1, 5'd2, 3'b101, 5'd3, op_reg}, ebreak_word};
    // random data words at word 16 and word 24
    while (prog.size() < 16) prog.push_back('0);
    prog.push_back($random(seed));
    while (prog.size() < 24) prog.push_back('0);
    prog.push_back($random(seed));
    reset_core();
    retire("load base", reset_pc, reset_pc + 4);
    retire("load lw", prog[word_index(reset_pc + 64)], reset_pc + 8);
    retire("load base offset", reset_pc + 128, reset_pc + 12);
    retire("load lw negative", prog[word_index(reset_pc + 128 - 32)], reset_pc + 16);
    retire("load unsupported", '0, reset_pc + 20);
endtask

task automatic test_halt();
    logic [xlen-1:0] held;
    prog = {i_type(12'd5, 5'd0, f3_add, 5'd1, op_imm), ebreak_word};
    reset_core();
    retire("halt addi", 32'd5, reset_pc + 4);
    wait_halt("halt");
    held = pc;
    check_word("halt pc", reset_pc + 4, held);
    repeat (10) begin
        @(posedge clk);
        @(negedge clk);
        check_word("halt pc hold", held, pc);
        check_flag("halt level", 1'b1, halted);
    end
endtask

//--- testbench/npc_tb.sv
module npc_tb import npc_pkg::*; ();

    logic clk;
    logic rst;
    logic load_en;
    logic [mem_aw-1:0] load_addr;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] alu_result;
    logic halted;

    // program image for the next reset with word 0 at reset_pc
    logic [xlen-1:0] prog [$];
    int seed = 82075;

    always #50 clk = ~clk;

    npc dut (
        .clk        (clk),
        .rst        (rst),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .pc         (pc),
        .alu_result (alu_result),
        .halted     (halted)
    );

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] exp,
                              input logic [xlen-1:0] act);
        if (act !== exp) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error %s: expected %b, actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    // hold reset for at least 8 cycles and load one word per falling edge
    task automatic reset_core();
        int n;
        @(negedge clk);
        rst = 1'b1;
        n = (prog.size() > 8) ? prog.size() : 8;
        for (int k = 0; k < n; k++) begin
            load_en = (k < prog.size());
            load_addr = mem_aw'(k);
            load_data = (k < prog.size()) ? prog[k] : '0;
            @(negedge clk);
        end
        load_en = 1'b0;
        rst = 1'b0;
    endtask

    // result is checked before the edge and pc after it
    task automatic retire(input string name, input logic [xlen-1:0] exp_result,
                          input logic [xlen-1:0] exp_pc);
        check_word(name, exp_result, alu_result);
        @(posedge clk);
        @(negedge clk);
        check_word(name, exp_pc, pc);
    endtask

    task automatic wait_halt(input string name);
        int cycles;
        cycles = 0;
        while (!halted && cycles < 200) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("%s: the core never halted within 200 cycles", name);
            stop_with_failure();
        end
    endtask

    // instruction encoders following the base ISA formats
    function automatic logic [xlen-1:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [xlen-1:0] r_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [4:0] rd);
        return {7'd0, rs2, rs1, f3_add, rd, op_reg};
    endfunction

    function automatic logic [xlen-1:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                               input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [xlen-1:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic logic [xlen-1:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic int word_index(input logic [xlen-1:0] addr);
        return int'(mem_aw'((addr - reset_pc) >> 2));
    endfunction

    `include "npc_tests.svh"

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        test_reset();
        test_arith();
        test_upper();
        test_jumps();
        test_load();
        test_halt();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- npc.f
+incdir+testbench
hw/npc_pkg.sv
hw/inst_decode.sv
hw/alu.sv
hw/reg_file.sv
hw/pmem.sv
hw/npc.sv
testbench/npc_tb.sv
